// ==== Makefile ====
# Verilator build and run of the convolution filter testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := conv_filter_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in its output
test: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/conv_pkg.sv ====
/*
 * shared definitions for the streaming convolution filter
 *  - pixel, coefficient, position and accumulator widths
 *  - typedefs for pixels, coefficients, positions and the filtered sum
 *  - default image and kernel geometry used by the top level
 */

package conv_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    // unsigned input pixel
    localparam int PIX_W = 8;
    // signed kernel coefficient
    localparam int COEF_W = 8;
    // row and column index
    localparam int POS_W = 16;

    // largest kernel area, 5x5
    localparam int MAX_TAPS = 25;

    // product of pixel and coefficient, plus sign, plus growth over all taps
    localparam int ACC_W = PIX_W + COEF_W + 1 + $clog2(MAX_TAPS);

    //////////////////////////////////////////////////////////////////////
    // types

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic [POS_W-1:0] pos_t;
    // full width signed result, never truncated
    typedef logic signed [ACC_W-1:0] acc_t;

    //////////////////////////////////////////////////////////////////////
    // default geometry

    localparam int DEF_IMG_WIDTH = 8;
    localparam int DEF_IMG_HEIGHT = 6;
    // square kernel edge, must be odd
    localparam int DEF_K_SIZE = 3;

endpackage

// ==== dv/conv_filter_asserts.sv ====
/*
 * timing assertions bound to the filter top level
 *  - output strobe two cycles after the input strobe
 *  - output position inside the image
 *  - output strobe low during reset and just after it
 */

`timescale 1ns/1ps

module conv_filter_asserts #(
    parameter int IMG_WIDTH = conv_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = conv_pkg::DEF_IMG_HEIGHT
) (
    input  logic            pclk_i,
    input  logic            rst_n_i,
    input  logic            in_valid_i,
    input  logic            out_valid_i,
    input  conv_pkg::pos_t  out_row_i,
    input  conv_pkg::pos_t  out_col_i
);

    int fail_count = 0;

    // window and pipe register, then the output register
    valid_latency: assert property (@(posedge pclk_i) out_valid_i |-> $past(in_valid_i, 2))
        else begin
            $error("output strobe without an input strobe two cycles earlier");
            fail_count++;
        end

    position_range: assert property (@(posedge pclk_i)
        out_valid_i |-> (int'(out_row_i) < IMG_HEIGHT && int'(out_col_i) < IMG_WIDTH))
        else begin
            $error("output position outside the image");
            fail_count++;
        end

    // reset clears the output register on the next edge
    quiet_in_reset: assert property (@(posedge pclk_i) !rst_n_i |=> !out_valid_i)
        else begin
            $error("output strobe while reset was asserted");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge pclk_i) $rose(rst_n_i) |=> !out_valid_i)
        else begin
            $error("output strobe in the cycle after reset");
            fail_count++;
        end

endmodule

bind conv_filter_top conv_filter_asserts #(
    .IMG_WIDTH   (IMG_WIDTH),
    .IMG_HEIGHT  (IMG_HEIGHT)
) u_asserts (
    .pclk_i      (pclk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (pixel_valid_i),
    .out_valid_i (pixel_valid_o),
    .out_row_i   (row_o),
    .out_col_i   (col_o)
);

// ==== dv/conv_filter_checker.sv ====
/*
 * output checker for the convolution filter testbench
 *  - store of every accepted pixel since the last reset
 *  - reference sum with constant extension at the borders
 *  - per output comparison of value, position and arrival cycle
 *  - per test report line and running totals
 */

`timescale 1ns/1ps

module conv_filter_checker #(
    parameter int IMG_WIDTH = conv_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = conv_pkg::DEF_IMG_HEIGHT,
    parameter int K_WIDTH = conv_pkg::DEF_K_SIZE,
    parameter int K_HEIGHT = conv_pkg::DEF_K_SIZE,
    parameter conv_pkg::pixel_t BORDER_VALUE = '0
) (
    input  logic              pclk_i,
    input  logic              rst_n_i,
    input  conv_pkg::pixel_t  pixel_i,
    input  logic              pixel_valid_i,
    input  conv_pkg::coef_t   coeffs_i [K_HEIGHT][K_WIDTH],
    // observed DUT outputs
    input  conv_pkg::acc_t    dut_pixel_i,
    input  logic              dut_valid_i,
    input  conv_pkg::pos_t    dut_row_i,
    input  conv_pkg::pos_t    dut_col_i
);
    import conv_pkg::*;

    localparam int MID_H = K_HEIGHT / 2;
    localparam int MID_W = K_WIDTH / 2;
    localparam int FRAME = IMG_WIDTH * IMG_HEIGHT;
    // inputs needed before the first output
    localparam int FILL = MID_H * IMG_WIDTH + MID_W;

    // raster stream since reset, index is n
    int stream [$];

    // expected outputs in arrival order
    int exp_val [$];
    int exp_row [$];
    int exp_col [$];
    int exp_due [$];

    int cycle = 0;
    int pending = 0;
    int test_checked = 0;
    int test_errors = 0;
    int total_checked = 0;
    int total_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    //////////////////////////////////////////////////////////////////////
    // reference model

    // correlation over the frame starting at base, border taps constant
    function automatic int expected_sum(input int base, input int row, input int col);
        int sum;
        int rr;
        int cc;
        int pix;
        sum = 0;
        for (int r = 0; r < K_HEIGHT; r++) begin
            for (int c = 0; c < K_WIDTH; c++) begin
                rr = row + r - MID_H;
                cc = col + c - MID_W;
                if (rr < 0 || rr >= IMG_HEIGHT || cc < 0 || cc >= IMG_WIDTH) begin
                    pix = int'(BORDER_VALUE);
                end else begin
                    pix = stream[base + rr * IMG_WIDTH + cc];
                end
                sum = sum + pix * int'(coeffs_i[r][c]);
            end
        end
        return sum;
    endfunction

    task automatic record_input(input int pix);
        int n;
        int p_abs;
        int p;
        n = stream.size();
        stream.push_back(pix);
        if (n >= FILL) begin
            // centre lags the newest pixel by the fill distance
            p_abs = n - FILL;
            p = p_abs % FRAME;
            exp_row.push_back(p / IMG_WIDTH);
            exp_col.push_back(p % IMG_WIDTH);
            exp_val.push_back(expected_sum(p_abs - p, p / IMG_WIDTH, p % IMG_WIDTH));
            exp_due.push_back(cycle + 2);
        end
    endtask

    task automatic drop_front();
        exp_val.delete(0);
        exp_row.delete(0);
        exp_col.delete(0);
        exp_due.delete(0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // comparison

    task automatic compare_output();
        int got;
        got = int'(dut_pixel_i);
        if (exp_due.size() == 0 || exp_due[0] != cycle) begin
            $display("unexpected output for (%0d,%0d) in cycle %0d, no input was due",
                     dut_row_i, dut_col_i, cycle);
            test_errors++;
        end else begin
            if (got != exp_val[0]) begin
                $display("ERROR %0t: pixel (%0d,%0d) expected %0d, got %0d",
                         $time, exp_row[0], exp_col[0], exp_val[0], got);
                test_errors++;
            end
            if (int'(dut_row_i) != exp_row[0] || int'(dut_col_i) != exp_col[0]) begin
                $display("ERROR %0t: position expected (%0d,%0d), got (%0d,%0d)",
                         $time, exp_row[0], exp_col[0], dut_row_i, dut_col_i);
                test_errors++;
            end
            test_checked++;
            drop_front();
        end
    endtask

    always @(posedge pclk_i) begin
        cycle++;
        if (dut_valid_i) begin
            compare_output();
        end
        while (exp_due.size() > 0 && exp_due[0] <= cycle) begin
            $display("missing output for (%0d,%0d), it was due in cycle %0d",
                     exp_row[0], exp_col[0], exp_due[0]);
            test_errors++;
            drop_front();
        end
        // a reset drops the stream and anything still in flight
        if (!rst_n_i) begin
            stream.delete();
            exp_val.delete();
            exp_row.delete();
            exp_col.delete();
            exp_due.delete();
        end else if (pixel_valid_i) begin
            record_input(int'(pixel_i));
        end
        pending = exp_due.size();
    end

    //////////////////////////////////////////////////////////////////////
    // per test report

    task automatic finish_test(input string name);
        if (exp_due.size() != 0) begin
            $display("%0d expected outputs never arrived", exp_due.size());
            test_errors += exp_due.size();
        end
        $display("test %-22s %0d outputs checked, %0d errors", name, test_checked, test_errors);
        total_checked += test_checked;
        total_errors += test_errors;
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        test_checked = 0;
        test_errors = 0;
    endtask

endmodule

// ==== dv/conv_filter_tb.sv ====
/*
 * testbench top for the streaming convolution filter
 *  - clock, reset and raster pixel stimulus
 *  - five tests, each followed by a flush frame of zeros
 *  - cycle watchdog and closing summary
 */

`timescale 1ns/1ps

module conv_filter_tb;
    import conv_pkg::*;

    localparam int IMG_WIDTH = DEF_IMG_WIDTH;
    localparam int IMG_HEIGHT = DEF_IMG_HEIGHT;
    localparam int K_SIZE = DEF_K_SIZE;
    localparam int MID = K_SIZE / 2;
    localparam pixel_t BORDER_VALUE = '0;
    localparam int FRAME = IMG_WIDTH * IMG_HEIGHT;
    localparam int N_TESTS = 5;

    // frame contents
    localparam int FRAME_RANDOM = 0;
    localparam int FRAME_WHITE = 1;
    localparam int FRAME_ZERO = 2;

    // kernel contents
    localparam int KERNEL_IDENTITY = 0;
    localparam int KERNEL_BOX = 1;
    localparam int KERNEL_RANDOM = 2;

    // stimulus cycles per test with flush frames and the longest gaps
    localparam int STIM_CYCLES = 3 * FRAME + 2 * FRAME + 4 * FRAME + 4 * 4 * FRAME
                               + FRAME / 2 + 2 * FRAME;
    // six resets of 8 cycles since test 5 resets twice
    localparam int RESET_CYCLES = 8 * 6;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + RESET_CYCLES;

    logic   pclk;
    logic   rst_n;
    pixel_t pixel;
    logic   pixel_valid;
    coef_t  coeffs [K_SIZE][K_SIZE];
    acc_t   pixel_out;
    logic   pixel_out_valid;
    pos_t   row_out;
    pos_t   col_out;

    int     cycle_count;

    conv_filter_top #(
        .IMG_WIDTH     (IMG_WIDTH),
        .IMG_HEIGHT    (IMG_HEIGHT),
        .K_WIDTH       (K_SIZE),
        .K_HEIGHT      (K_SIZE),
        .BORDER_VALUE  (BORDER_VALUE)
    ) dut0 (
        .pclk_i        (pclk),
        .rst_n_i       (rst_n),
        .pixel_i       (pixel),
        .pixel_valid_i (pixel_valid),
        .coeffs_i      (coeffs),
        .pixel_o       (pixel_out),
        .pixel_valid_o (pixel_out_valid),
        .row_o         (row_out),
        .col_o         (col_out)
    );

    conv_filter_checker #(
        .IMG_WIDTH     (IMG_WIDTH),
        .IMG_HEIGHT    (IMG_HEIGHT),
        .K_WIDTH       (K_SIZE),
        .K_HEIGHT      (K_SIZE),
        .BORDER_VALUE  (BORDER_VALUE)
    ) chk0 (
        .pclk_i        (pclk),
        .rst_n_i       (rst_n),
        .pixel_i       (pixel),
        .pixel_valid_i (pixel_valid),
        .coeffs_i      (coeffs),
        .dut_pixel_i   (pixel_out),
        .dut_valid_i   (pixel_out_valid),
        .dut_row_i     (row_out),
        .dut_col_i     (col_out)
    );

    //////////////////////////////////////////////////////////////////////
    // clock and watchdog

    initial begin
        pclk = 1'b0;
        forever #20 pclk = ~pclk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge pclk);
            cycle_count++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks entered and left 2 ns after a rising edge

    task automatic apply_reset();
        rst_n = 1'b0;
        pixel_valid = 1'b0;
        repeat (8) begin
            @(posedge pclk);
            #2;
        end
        rst_n = 1'b1;
    endtask

    task automatic send_pixel(input pixel_t value, input int gap);
        pixel = value;
        pixel_valid = 1'b1;
        @(posedge pclk);
        #2;
        pixel_valid = 1'b0;
        // idle cycles freeze the filter
        repeat (gap) begin
            @(posedge pclk);
            #2;
        end
    endtask

    task automatic send_frame(input int kind, input int max_gap);
        pixel_t value;
        int     gap;
        for (int i = 0; i < FRAME; i++) begin
            case (kind)
                FRAME_RANDOM: value = pixel_t'($urandom);
                FRAME_WHITE:  value = 8'hff;
                default:      value = '0;
            endcase
            gap = 0;
            if (max_gap > 0) begin
                gap = int'($urandom % 32'(max_gap + 1));
            end
            send_pixel(value, gap);
        end
    endtask

    task automatic load_kernel(input int kind);
        for (int r = 0; r < K_SIZE; r++) begin
            for (int c = 0; c < K_SIZE; c++) begin
                case (kind)
                    KERNEL_IDENTITY: coeffs[r][c] = (r == MID && c == MID) ? coef_t'(1) : '0;
                    KERNEL_BOX:      coeffs[r][c] = coef_t'(1);
                    default:         coeffs[r][c] = coef_t'($urandom);
                endcase
            end
        end
    endtask

    // wait for every expected output and a few more cycles for strays
    task automatic drain();
        while (chk0.pending > 0) begin
            @(posedge pclk);
            #2;
        end
        repeat (4) begin
            @(posedge pclk);
            #2;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin : main
        void'($urandom(32'hff83));
        rst_n = 1'b0;
        pixel = '0;
        pixel_valid = 1'b0;
        load_kernel(KERNEL_IDENTITY);

        // centre tap only so the output mirrors the input
        apply_reset();
        load_kernel(KERNEL_IDENTITY);
        send_frame(FRAME_RANDOM, 0);
        send_frame(FRAME_RANDOM, 0);
        send_frame(FRAME_ZERO, 0);
        drain();
        chk0.finish_test("identity kernel");

        // white frame where corners see 4 taps, edges 6 and the interior 9
        apply_reset();
        load_kernel(KERNEL_BOX);
        send_frame(FRAME_WHITE, 0);
        send_frame(FRAME_ZERO, 0);
        drain();
        chk0.finish_test("box sum at borders");

        // signed kernel over random frames
        apply_reset();
        load_kernel(KERNEL_RANDOM);
        for (int f = 0; f < 3; f++) begin
            send_frame(FRAME_RANDOM, 0);
        end
        send_frame(FRAME_ZERO, 0);
        drain();
        chk0.finish_test("signed random kernel");

        // same kernel with 0 to 3 idle cycles between strobes
        apply_reset();
        for (int f = 0; f < 3; f++) begin
            send_frame(FRAME_RANDOM, 3);
        end
        send_frame(FRAME_ZERO, 3);
        drain();
        chk0.finish_test("idle gaps");

        // reset halfway through a frame and restart from (0,0)
        apply_reset();
        for (int i = 0; i < FRAME / 2; i++) begin
            send_pixel(pixel_t'($urandom), 0);
        end
        apply_reset();
        send_frame(FRAME_RANDOM, 0);
        send_frame(FRAME_ZERO, 0);
        drain();
        chk0.finish_test("reset mid-stream");

        $display("summary: %0d of %0d tests clean, %0d outputs checked, %0d errors, %0d %s",
                 chk0.tests_run - chk0.tests_failed, N_TESTS, chk0.total_checked,
                 chk0.total_errors, dut0.u_asserts.fail_count, "assertion failures");
        if (chk0.total_errors == 0 && dut0.u_asserts.fail_count == 0 &&
            chk0.tests_run == N_TESTS) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== mac/window_mac.sv ====
/*
 * combining stage of the filter
 *  - constant extension of taps outside the image
 *  - single-cycle signed multiply-accumulate, correlation orientation
 *  - registered sum, position and valid bit
 */

`timescale 1ns/1ps

module window_mac #(
    parameter int IMG_WIDTH = conv_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = conv_pkg::DEF_IMG_HEIGHT,
    parameter int K_WIDTH = conv_pkg::DEF_K_SIZE,
    parameter int K_HEIGHT = conv_pkg::DEF_K_SIZE,
    parameter conv_pkg::pixel_t BORDER_VALUE = '0
) (
    input  logic              pclk_i,
    input  logic              rst_n_i,
    // reversed window, [0][0] newest
    input  conv_pkg::pixel_t  window_i [K_HEIGHT][K_WIDTH],
    // position of the window centre
    input  conv_pkg::pos_t    pipe_row_i,
    input  conv_pkg::pos_t    pipe_col_i,
    input  logic              pipe_full_i,
    input  logic              step_i,
    input  conv_pkg::coef_t   coeffs_i [K_HEIGHT][K_WIDTH],
    output conv_pkg::acc_t    pixel_o,
    output logic              pixel_valid_o,
    output conv_pkg::pos_t    row_o,
    output conv_pkg::pos_t    col_o
);
    import conv_pkg::*;

    localparam int MID_H = K_HEIGHT / 2;
    localparam int MID_W = K_WIDTH / 2;

    // pixel with a zero sign bit times a signed coefficient
    localparam int PROD_W = PIX_W + 1 + COEF_W;

    // window after constant extension
    pixel_t ext_pix [K_HEIGHT][K_WIDTH];

    // combinational sum of all taps
    acc_t   mac_sum;

    // output registers
    acc_t   pixel_q;
    pos_t   row_q;
    pos_t   col_q;
    logic   valid_q;

    //////////////////////////////////////////////////////////////////////
    // constant extension

    always_comb begin
        int tap_row;
        int tap_col;
        for (int r = 0; r < K_HEIGHT; r++) begin
            for (int c = 0; c < K_WIDTH; c++) begin
                // window is reversed, tap [r][c] lies MID_H-r rows below the centre
                tap_row = int'(pipe_row_i) + MID_H - r;
                tap_col = int'(pipe_col_i) + MID_W - c;
                if (tap_row < 0 || tap_row >= IMG_HEIGHT ||
                    tap_col < 0 || tap_col >= IMG_WIDTH) begin
                    ext_pix[r][c] = BORDER_VALUE;
                end else begin
                    ext_pix[r][c] = window_i[r][c];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // multiply-accumulate

    always_comb begin
        logic signed [PIX_W:0]    tap_s;
        logic signed [PROD_W-1:0] prod;
        acc_t                     sum;
        sum = '0;
        for (int r = 0; r < K_HEIGHT; r++) begin
            for (int c = 0; c < K_WIDTH; c++) begin
                tap_s = signed'({1'b0, ext_pix[r][c]});
                // mirrored coefficient index undoes the reversed window
                prod = tap_s * coeffs_i[K_HEIGHT-1-r][K_WIDTH-1-c];
                sum = sum + acc_t'(prod);
            end
        end
        mac_sum = sum;
    end

    //////////////////////////////////////////////////////////////////////
    // output registers

    // result and position captured on step only
    always_ff @(posedge pclk_i) begin
        if (step_i) begin
            pixel_q <= mac_sum;
            row_q   <= pipe_row_i;
            col_q   <= pipe_col_i;
        end
    end

    // one-cycle valid, held off until the pipe is full
    always_ff @(posedge pclk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= step_i & pipe_full_i;
        end
    end

    assign pixel_o       = pixel_q;
    assign pixel_valid_o = valid_q;
    assign row_o         = row_q;
    assign col_o         = col_q;

endmodule

// ==== source/conv_filter_top.sv ====
/*
 * streaming 2-D convolution filter, top level
 *  - row buffers and window registers
 *  - pipe position tracker
 *  - border extension and multiply-accumulate stage
 */

`timescale 1ns/1ps

module conv_filter_top #(
    parameter int IMG_WIDTH = conv_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = conv_pkg::DEF_IMG_HEIGHT,
    parameter int K_WIDTH = conv_pkg::DEF_K_SIZE,
    parameter int K_HEIGHT = conv_pkg::DEF_K_SIZE,
    parameter conv_pkg::pixel_t BORDER_VALUE = '0
) (
    input  logic              pclk_i,
    input  logic              rst_n_i,
    // raster ordered input, one pixel per strobe
    input  conv_pkg::pixel_t  pixel_i,
    input  logic              pixel_valid_i,
    // kernel, held static by the driver
    input  conv_pkg::coef_t   coeffs_i [K_HEIGHT][K_WIDTH],
    // filtered pixel and its raster position
    output conv_pkg::acc_t    pixel_o,
    output logic              pixel_valid_o,
    output conv_pkg::pos_t    row_o,
    output conv_pkg::pos_t    col_o
);
    import conv_pkg::*;

    // no back-pressure, every strobe is taken
    logic   accept;

    // window around the pipe position, newest pixel at [0][0]
    pixel_t window [K_HEIGHT][K_WIDTH];

    // pipe position and fill state
    pos_t   pipe_row;
    pos_t   pipe_col;
    logic   pipe_full;
    logic   step;

    assign accept = pixel_valid_i;

    line_window #(
        .IMG_WIDTH (IMG_WIDTH),
        .K_WIDTH   (K_WIDTH),
        .K_HEIGHT  (K_HEIGHT)
    ) u_line_window (
        .pclk_i    (pclk_i),
        .rst_n_i   (rst_n_i),
        .pixel_i   (pixel_i),
        .accept_i  (accept),
        .window_o  (window)
    );

    pixel_tracker #(
        .IMG_WIDTH   (IMG_WIDTH),
        .IMG_HEIGHT  (IMG_HEIGHT),
        .K_WIDTH     (K_WIDTH),
        .K_HEIGHT    (K_HEIGHT)
    ) u_pixel_tracker (
        .pclk_i      (pclk_i),
        .rst_n_i     (rst_n_i),
        .accept_i    (accept),
        .pipe_row_o  (pipe_row),
        .pipe_col_o  (pipe_col),
        .pipe_full_o (pipe_full),
        .step_o      (step)
    );

    // combines the window with the pipe position one cycle after accept
    window_mac #(
        .IMG_WIDTH     (IMG_WIDTH),
        .IMG_HEIGHT    (IMG_HEIGHT),
        .K_WIDTH       (K_WIDTH),
        .K_HEIGHT      (K_HEIGHT),
        .BORDER_VALUE  (BORDER_VALUE)
    ) u_window_mac (
        .pclk_i        (pclk_i),
        .rst_n_i       (rst_n_i),
        .window_i      (window),
        .pipe_row_i    (pipe_row),
        .pipe_col_i    (pipe_col),
        .pipe_full_i   (pipe_full),
        .step_i        (step),
        .coeffs_i      (coeffs_i),
        .pixel_o       (pixel_o),
        .pixel_valid_o (pixel_valid_o),
        .row_o         (row_o),
        .col_o         (col_o)
    );

endmodule

// ==== source/pixel_tracker.sv ====
/*
 * pipe position tracker
 *  - raster position of the window centre
 *  - pipe-full flag, set once the first centre pixel is in the window
 *  - accept strobe delayed by one cycle
 */

`timescale 1ns/1ps

module pixel_tracker #(
    parameter int IMG_WIDTH = conv_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT = conv_pkg::DEF_IMG_HEIGHT,
    parameter int K_WIDTH = conv_pkg::DEF_K_SIZE,
    parameter int K_HEIGHT = conv_pkg::DEF_K_SIZE
) (
    input  logic            pclk_i,
    input  logic            rst_n_i,
    input  logic            accept_i,
    output conv_pkg::pos_t  pipe_row_o,
    output conv_pkg::pos_t  pipe_col_o,
    output logic            pipe_full_o,
    output logic            step_o
);
    import conv_pkg::*;

    // kernel half sizes
    localparam int MID_H = K_HEIGHT / 2;
    localparam int MID_W = K_WIDTH / 2;

    // one raster step before the centre of pixel (0,0) for the first accept
    localparam pos_t START_ROW = pos_t'(IMG_HEIGHT - 1 - MID_H);
    localparam pos_t START_COL = pos_t'(IMG_WIDTH - 1 - MID_W);

    pos_t row_q;
    pos_t col_q;
    logic full_q;
    logic step_q;

    // frame edges of the current position
    logic last_col;
    logic last_row;

    assign last_col = (col_q == pos_t'(IMG_WIDTH - 1));
    assign last_row = (row_q == pos_t'(IMG_HEIGHT - 1));

    //////////////////////////////////////////////////////////////////////
    // pipe position, raster order with wrap at frame end

    always_ff @(posedge pclk_i) begin
        if (!rst_n_i) begin
            row_q <= START_ROW;
            col_q <= START_COL;
        end else if (accept_i) begin
            if (last_col) begin
                col_q <= '0;
                // wrap to row 0 at the end of the frame
                row_q <= last_row ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fill flag and step strobe

    always_ff @(posedge pclk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
            step_q <= 1'b0;
        end else begin
            step_q <= accept_i;
            // the accept that moves the centre onto (0,0) fills the pipe
            if (accept_i && last_row && last_col) begin
                full_q <= 1'b1;
            end
        end
    end

    assign pipe_row_o  = row_q;
    assign pipe_col_o  = col_q;
    assign pipe_full_o = full_q;
    assign step_o      = step_q;

endmodule

// ==== sources.f ====
common/conv_pkg.sv
window/line_window.sv
source/pixel_tracker.sv
mac/window_mac.sv
source/conv_filter_top.sv
dv/conv_filter_asserts.sv
dv/conv_filter_checker.sv
dv/conv_filter_tb.sv

// ==== window/line_window.sv ====
/*
 * row buffers and window shift registers
 *  - K_HEIGHT-1 chained row buffers, each IMG_WIDTH deep
 *  - K_HEIGHT x K_WIDTH window, shifted one column per accept
 */

`timescale 1ns/1ps

module line_window #(
    parameter int IMG_WIDTH = conv_pkg::DEF_IMG_WIDTH,
    parameter int K_WIDTH = conv_pkg::DEF_K_SIZE,
    parameter int K_HEIGHT = conv_pkg::DEF_K_SIZE
) (
    input  logic              pclk_i,
    input  logic              rst_n_i,
    input  conv_pkg::pixel_t  pixel_i,
    input  logic              accept_i,
    // [0][0] newest pixel, [K_HEIGHT-1][K_WIDTH-1] oldest
    output conv_pkg::pixel_t  window_o [K_HEIGHT][K_WIDTH]
);
    import conv_pkg::*;

    // a 1-row kernel still keeps one buffer so the array stays legal
    localparam int N_BUF = (K_HEIGHT > 1) ? K_HEIGHT - 1 : 1;

    //////////////////////////////////////////////////////////////////////
    // storage

    // row buffers as plain shift registers
    // [b][0] is the entry, [b][IMG_WIDTH-1] the tail
    pixel_t row_buf [N_BUF][IMG_WIDTH];

    // window registers, stored reversed
    pixel_t win_q [K_HEIGHT][K_WIDTH];

    // frozen while reset is asserted and on idle cycles
    logic   shift_en;

    assign shift_en = accept_i & rst_n_i;

    //////////////////////////////////////////////////////////////////////
    // row buffers

    always_ff @(posedge pclk_i) begin
        if (shift_en) begin
            // move every buffer along by one pixel
            for (int b = 0; b < N_BUF; b++) begin
                for (int i = IMG_WIDTH - 1; i > 0; i--) begin
                    row_buf[b][i] <= row_buf[b][i-1];
                end
            end

            // first buffer takes the incoming pixel
            row_buf[0][0] <= pixel_i;

            // each later buffer is fed by the tail of the one before
            for (int b = 1; b < N_BUF; b++) begin
                row_buf[b][0] <= row_buf[b-1][IMG_WIDTH-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // window shift registers

    always_ff @(posedge pclk_i) begin
        if (shift_en) begin
            // shift each window row one column to the right
            for (int r = 0; r < K_HEIGHT; r++) begin
                for (int c = K_WIDTH - 1; c > 0; c--) begin
                    win_q[r][c] <= win_q[r][c-1];
                end
            end

            // row 0 is the current image row
            win_q[0][0] <= pixel_i;

            // row r is r image rows back, taken from buffer r-1
            for (int r = 1; r < K_HEIGHT; r++) begin
                win_q[r][0] <= row_buf[r-1][IMG_WIDTH-1];
            end
        end
    end

    // window straight from the registers, no border handling here
    assign window_o = win_q;

endmodule
